/* tb.f */
rtl/led_pkg.sv
rtl/button_color_request.sv
rtl/color_fifo.sv
rtl/ws2812_serializer.sv
rtl/led_cartridge_top.sv
tb/tb_clock_gen.sv
tb/tb_led_cartridge.sv

/* tb/tb_led_cartridge.sv */
`default_nettype none

module tb_led_cartridge;

	localparam int FIFO_DEPTH   = 4;
	localparam int LATCH_CYCLES = 100;
	localparam int FRAME_CYCLES = 24 * led_pkg::BIT_CYCLES + LATCH_CYCLES;
	localparam int IDLE_WINDOW  = 2 * FRAME_CYCLES;		// Quiet time after each row
	localparam int N_ROWS       = 5;
	localparam int MAX_FRAMES   = 1 + FIFO_DEPTH;
	localparam logic [31:0] LFSR_SEED = 32'h1573_37c9;

	// Presets in wire order, green then red then blue
	localparam led_pkg::grb_t EXP_BUTTON0 = {8'd20, 8'd100, 8'd0};		// Red 100, green 20
	localparam led_pkg::grb_t EXP_BUTTON1 = {8'd70, 8'd0, 8'd100};		// Green 70, blue 100

	logic       clk14m;
	logic       ff_reset_n;
	logic [1:0] button;
	logic       ws2812_led;
	logic       sending;

	// Stimulus table, press i uses pats[2*i+1:2*i]
	logic [15:0]   row_pats   [N_ROWS];
	int            row_count  [N_ROWS];		// Number of presses
	int            row_frames [N_ROWS];		// Frames expected
	led_pkg::grb_t row_exp    [N_ROWS][MAX_FRAMES];

	logic [31:0] lfsr_state;

	// Decoder state
	led_pkg::grb_t frames [$];		// Decoded words in arrival order
	led_pkg::grb_t shift_word;
	logic          prev_led;
	int            high_cnt;
	int            low_cnt;		// Low samples since the last falling edge
	int            last_high;
	int            bit_idx;
	logic          in_frame;
	logic          after_frame;		// At least one frame seen

	tb_clock_gen #(
		.PERIOD       (20),
		.RESET_CYCLES (3)
	) u_clock_gen (
		.clk14m     (clk14m),
		.ff_reset_n (ff_reset_n)
	);

	led_cartridge_top #(
		.FIFO_DEPTH   (FIFO_DEPTH),
		.LATCH_CYCLES (LATCH_CYCLES)
	) u_dut (
		.clk14m     (clk14m),
		.ff_reset_n (ff_reset_n),
		.button     (button),
		.ws2812_led (ws2812_led),
		.sending    (sending)
	);

	// --------------------
	// Error reporting
	// --------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_grb(input string name, input led_pkg::grb_t got,
	                         input led_pkg::grb_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("ERR %s: got 0x%06h, expected 0x%06h", name, got, exp));
		end
	endtask

	// Either of two legal widths
	task automatic check_width(input string name, input int got, input int exp_a,
	                           input int exp_b);
		if (got != exp_a && got != exp_b) begin
			stop_on_error($sformatf("ERR %s: got 0x%0h, expected 0x%0h or 0x%0h",
			                        name, got, exp_a, exp_b));
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
		end
	endtask

	// --------------------
	// Random gaps
	// --------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);		// Galois form
	endfunction

	// Four fresh bits, 2 to 17 cycles
	task automatic next_gap(output int gap);
		int val;
		val = 0;
		for (int i = 0; i < 4; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			val = (val << 1) | lfsr_state[0];
		end
		gap = val + 2;
	endtask

	// --------------------
	// LED line decoder
	// --------------------
	always @(posedge clk14m) begin
		if (ff_reset_n) begin
			if (ws2812_led) begin
				if (!prev_led) begin		// Rising edge
					if (in_frame) begin
						check_width("bit_period", last_high + low_cnt,
						            led_pkg::BIT_CYCLES, led_pkg::BIT_CYCLES);
					end else begin
						if (after_frame && low_cnt < LATCH_CYCLES) begin
							stop_on_error("next frame started before the latch period ended");
						end
						in_frame   = 1'b1;		// New frame
						bit_idx    = 0;
						shift_word = '0;
					end
					high_cnt = 0;
				end
				high_cnt = high_cnt + 1;
				check_level("sending", sending, 1'b1);
			end else begin
				if (prev_led) begin		// Falling edge ends the high part
					check_width("high_width", high_cnt, led_pkg::T0H_CYCLES,
					            led_pkg::T1H_CYCLES);
					shift_word = {shift_word[22:0], (high_cnt == led_pkg::T1H_CYCLES)};
					bit_idx    = bit_idx + 1;
					last_high  = high_cnt;
					low_cnt    = 0;
				end
				low_cnt = low_cnt + 1;
				if (in_frame || (after_frame && low_cnt <= LATCH_CYCLES)) begin
					check_level("sending", sending, 1'b1);		// Held through the latch
				end
				if (in_frame && low_cnt > led_pkg::BIT_CYCLES) begin
					if (bit_idx != 24) begin
						stop_on_error($sformatf("frame ended after %0d bits instead of 24",
						                        bit_idx));
					end
					frames.push_back(shift_word);
					in_frame    = 1'b0;
					after_frame = 1'b1;
				end
			end
			prev_led = ws2812_led;
		end
	end

	// --------------------
	// Stimulus and waits
	// --------------------
	task automatic load_table();
		for (int r = 0; r < N_ROWS; r++) begin
			for (int f = 0; f < MAX_FRAMES; f++) begin
				row_exp[r][f] = '0;
			end
		end
		row_pats[0] = 16'h0001;		// Button 0 alone
		row_count[0] = 1;
		row_frames[0] = 1;
		row_exp[0][0] = EXP_BUTTON0;
		row_pats[1] = 16'h0002;		// Button 1 alone
		row_count[1] = 1;
		row_frames[1] = 1;
		row_exp[1][0] = EXP_BUTTON1;
		row_pats[2] = 16'h0019;		// Presses 0, 1, 0
		row_count[2] = 3;
		row_frames[2] = 3;
		row_exp[2][0] = EXP_BUTTON0;
		row_exp[2][1] = EXP_BUTTON1;
		row_exp[2][2] = EXP_BUTTON0;
		row_pats[3] = 16'h5555;		// Eight presses overflow the FIFO
		row_count[3] = 8;
		row_frames[3] = 1 + FIFO_DEPTH;
		for (int f = 0; f < 1 + FIFO_DEPTH; f++) begin
			row_exp[3][f] = EXP_BUTTON0;
		end
		row_pats[4] = 16'h0003;		// Both at once, button 0 wins
		row_count[4] = 1;
		row_frames[4] = 1;
		row_exp[4][0] = EXP_BUTTON0;
	endtask

	task automatic press_buttons(input logic [1:0] pat);
		int gap;
		next_gap(gap);
		@(posedge clk14m);
		button <= pat;
		repeat (3) @(posedge clk14m);		// Hold 3 cycles
		button <= 2'b00;
		repeat (gap) @(posedge clk14m);
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (!ff_reset_n) begin
			@(negedge clk14m);
			cycles = cycles + 1;
			if (cycles > 20) stop_on_error("timed out waiting for reset release");
		end
	endtask

	task automatic wait_frames(input int n, input int limit);
		int cycles;
		cycles = 0;
		while (frames.size() < n) begin
			@(negedge clk14m);
			cycles = cycles + 1;
			if (cycles > limit) stop_on_error("timed out waiting for LED frames");
		end
	endtask

	task automatic wait_sending_low();
		int cycles;
		cycles = 0;
		while (sending) begin
			@(negedge clk14m);
			cycles = cycles + 1;
			if (cycles > 2 * FRAME_CYCLES) stop_on_error("timed out waiting for sending to fall");
		end
	endtask

	// Line and status both quiet for n cycles
	task automatic check_idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk14m);
			check_level("ws2812_led", ws2812_led, 1'b0);
			check_level("sending", sending, 1'b0);
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial begin
		int limit;
		button      = 2'b00;
		lfsr_state  = LFSR_SEED;
		prev_led    = 1'b0;
		high_cnt    = 0;
		low_cnt     = 0;
		last_high   = 0;
		bit_idx     = 0;
		in_frame    = 1'b0;
		after_frame = 1'b0;
		shift_word  = '0;
		load_table();
		wait_reset_release();
		check_idle(50);		// Quiet after reset
		for (int r = 0; r < N_ROWS; r++) begin
			frames.delete();
			for (int p = 0; p < row_count[r]; p++) begin
				press_buttons(row_pats[r][2*p +: 2]);
			end
			limit = row_frames[r] * (FRAME_CYCLES + 20) + 500;
			wait_frames(row_frames[r], limit);
			wait_sending_low();
			check_idle(IDLE_WINDOW);		// Nothing more may follow
			if (frames.size() != row_frames[r]) begin
				stop_on_error($sformatf("row %0d produced %0d frames instead of %0d",
				                        r, frames.size(), row_frames[r]));
			end
			for (int f = 0; f < row_frames[r]; f++) begin
				check_grb($sformatf("frame_%0d_%0d", r, f), frames[f], row_exp[r][f]);
			end
		end
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 20,		// Clock period in time units
	parameter int RESET_CYCLES = 3		// Reset held low this many cycles
) (
	output logic clk14m,
	output logic ff_reset_n
);

	// Free running clock
	initial begin
		clk14m = 1'b0;
		forever #(PERIOD / 2) clk14m = ~clk14m;
	end

	// Reset released on a rising edge
	initial begin
		ff_reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk14m);
		ff_reset_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/led_cartridge_top.sv */
`default_nettype none

module led_cartridge_top #(
	parameter int FIFO_DEPTH   = 4,		// Queued requests
	parameter int LATCH_CYCLES = 800		// WS2812 reset time in clk14m cycles
) (
	input  wire logic       clk14m,		// About 14.318 MHz
	input  wire logic       ff_reset_n,
	input  wire logic [1:0] button,		// KEY1, KEY2
	output logic            ws2812_led,
	output logic            sending
);

	logic          w_wr;
	led_pkg::grb_t w_wdata;
	logic          w_rd;
	led_pkg::grb_t w_rdata;
	logic          w_empty;
	logic          w_full;

	// --------------------
	// Buttons to requests
	// --------------------
	button_color_request u_request (
		.clk14m     (clk14m),
		.ff_reset_n (ff_reset_n),
		.button     (button),
		.full       (w_full),
		.wr         (w_wr),
		.wdata      (w_wdata)
	);

	// --------------------
	// Request queue
	// --------------------
	color_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk14m     (clk14m),
		.ff_reset_n (ff_reset_n),
		.wr         (w_wr),
		.wdata      (w_wdata),
		.rd         (w_rd),
		.rdata      (w_rdata),
		.empty      (w_empty),
		.full       (w_full)
	);

	// --------------------
	// LED line driver
	// --------------------
	ws2812_serializer #(
		.LATCH_CYCLES (LATCH_CYCLES)
	) u_serializer (
		.clk14m     (clk14m),
		.ff_reset_n (ff_reset_n),
		.empty      (w_empty),
		.rdata      (w_rdata),
		.rd         (w_rd),
		.sending    (sending),
		.ws2812_led (ws2812_led)
	);

endmodule

`default_nettype wire

/* rtl/ws2812_serializer.sv */
`default_nettype none

module ws2812_serializer #(
	parameter int LATCH_CYCLES = 800		// Reset low time, 800 is about 56 us
) (
	input  wire logic           clk14m,
	input  wire logic           ff_reset_n,
	input  wire logic           empty,		// Nothing queued
	input  wire led_pkg::grb_t  rdata,		// Oldest queued colour
	output logic                rd,			// Pop strobe
	output logic                sending,		// Frame or latch in progress
	output logic                ws2812_led		// LED data line
);

	// Counter must reach both the bit length and the latch length
	localparam int MAX_CYCLES = (LATCH_CYCLES > led_pkg::BIT_CYCLES) ?
	                            LATCH_CYCLES : led_pkg::BIT_CYCLES;
	localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

	localparam logic [CNT_W-1:0] T0H_LAST   = CNT_W'(led_pkg::T0H_CYCLES - 1);
	localparam logic [CNT_W-1:0] T1H_LAST   = CNT_W'(led_pkg::T1H_CYCLES - 1);
	localparam logic [CNT_W-1:0] BIT_LAST   = CNT_W'(led_pkg::BIT_CYCLES - 1);
	localparam logic [CNT_W-1:0] LATCH_LAST = CNT_W'(LATCH_CYCLES - 1);

	led_pkg::ser_state_t ff_state;
	led_pkg::grb_t       ff_shift;		// Current bit at the MSB
	logic [4:0]          ff_bit_cnt;		// Bits already finished in this frame
	logic [CNT_W-1:0]    ff_cnt;		// Cycles within a bit or the latch
	logic [CNT_W-1:0]    w_high_last;
	logic                w_last_bit;

	// --------------------
	// Pop and status
	// --------------------
	// Pop in the idle cycle, the word loads on the same edge
	assign rd      = (ff_state == led_pkg::ST_IDLE) && !empty;
	assign sending = (ff_state != led_pkg::ST_IDLE);

	// High time picked by the bit being sent
	assign w_high_last = ff_shift[23] ? T1H_LAST : T0H_LAST;
	assign w_last_bit  = (ff_bit_cnt == 5'd23);

	// --------------------
	// Bit timing FSM
	// --------------------
	always_ff @(posedge clk14m or negedge ff_reset_n) begin
		if (!ff_reset_n) begin
			ff_state   <= led_pkg::ST_IDLE;
			ff_bit_cnt <= 5'd0;
			ff_cnt     <= '0;
			ws2812_led <= 1'b0;
		end else begin
			case (ff_state)
				led_pkg::ST_IDLE: begin
					if (rd) begin
						ff_state   <= led_pkg::ST_HIGH;
						ff_bit_cnt <= 5'd0;
						ff_cnt     <= '0;
						ws2812_led <= 1'b1;		// First bit starts right away
					end
				end

				led_pkg::ST_HIGH: begin
					ff_cnt <= ff_cnt + 1'b1;		// Keeps running across the bit
					if (ff_cnt == w_high_last) begin
						ff_state   <= led_pkg::ST_LOW;
						ws2812_led <= 1'b0;
					end
				end

				led_pkg::ST_LOW: begin
					if (ff_cnt == BIT_LAST) begin
						ff_cnt <= '0;
						if (w_last_bit) begin
							ff_state <= led_pkg::ST_LATCH;		// Line stays low
						end else begin
							ff_state   <= led_pkg::ST_HIGH;
							ff_bit_cnt <= ff_bit_cnt + 1'b1;
							ws2812_led <= 1'b1;
						end
					end else begin
						ff_cnt <= ff_cnt + 1'b1;
					end
				end

				led_pkg::ST_LATCH: begin
					if (ff_cnt == LATCH_LAST) begin
						ff_state <= led_pkg::ST_IDLE;		// LEDs have latched
						ff_cnt   <= '0;
					end else begin
						ff_cnt <= ff_cnt + 1'b1;
					end
				end

				default: begin
					ff_state   <= led_pkg::ST_IDLE;
					ws2812_led <= 1'b0;
				end
			endcase
		end
	end

	// --------------------
	// Shift register
	// --------------------
	always_ff @(posedge clk14m) begin
		if (rd) begin
			ff_shift <= rdata;
		end else if (ff_state == led_pkg::ST_LOW && ff_cnt == BIT_LAST) begin
			ff_shift <= {ff_shift[22:0], 1'b0};		// Next bit to the MSB
		end
	end

endmodule

`default_nettype wire

/* rtl/color_fifo.sv */
`default_nettype none

module color_fifo #(
	parameter int FIFO_DEPTH = 4		// Power of two, 2 to 16
) (
	input  wire logic           clk14m,
	input  wire logic           ff_reset_n,
	input  wire logic           wr,			// Push strobe
	input  wire led_pkg::grb_t  wdata,
	input  wire logic           rd,			// Pop strobe
	output led_pkg::grb_t       rdata,		// Oldest entry, always shown
	output logic                empty,
	output logic                full
);

	localparam int ADDR_W  = $clog2(FIFO_DEPTH);
	localparam int COUNT_W = ADDR_W + 1;		// Holds 0 to FIFO_DEPTH

	led_pkg::grb_t      mem [FIFO_DEPTH];
	logic [ADDR_W-1:0]  ff_wr_ptr;
	logic [ADDR_W-1:0]  ff_rd_ptr;
	logic [COUNT_W-1:0] ff_count;
	logic               w_push;
	logic               w_pop;

	// --------------------
	// Flags
	// --------------------
	assign empty = (ff_count == '0);
	assign full  = (ff_count == COUNT_W'(FIFO_DEPTH));

	// Strobes that meet a blocked side are ignored
	assign w_push = wr && !full;
	assign w_pop  = rd && !empty;

	// First word fall-through
	assign rdata = mem[ff_rd_ptr];

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge clk14m) begin
		if (w_push) begin
			mem[ff_wr_ptr] <= wdata;
		end
	end

	// Pointers wrap on their own at a power of two
	always_ff @(posedge clk14m or negedge ff_reset_n) begin
		if (!ff_reset_n) begin
			ff_wr_ptr <= '0;
			ff_rd_ptr <= '0;
		end else begin
			if (w_push) begin
				ff_wr_ptr <= ff_wr_ptr + 1'b1;
			end
			if (w_pop) begin
				ff_rd_ptr <= ff_rd_ptr + 1'b1;
			end
		end
	end

	// Entry count
	always_ff @(posedge clk14m or negedge ff_reset_n) begin
		if (!ff_reset_n) begin
			ff_count <= '0;
		end else begin
			case ({w_push, w_pop})
				2'b10:   ff_count <= ff_count + 1'b1;
				2'b01:   ff_count <= ff_count - 1'b1;
				default: ff_count <= ff_count;		// Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/button_color_request.sv */
`default_nettype none

module button_color_request (
	input  wire logic           clk14m,
	input  wire logic           ff_reset_n,
	input  wire logic [1:0]     button,		// Raw push buttons, active high
	input  wire logic           full,		// FIFO has no room
	output logic                wr,			// One-cycle write strobe
	output led_pkg::grb_t       wdata		// Preset colour, valid with wr
);

	logic [1:0] ff_sync0;		// First metastability stage
	logic [1:0] ff_sync1;		// Synchronized level
	logic [1:0] ff_prev;		// Level one cycle earlier
	logic [1:0] w_rise;
	logic       w_req;

	// --------------------
	// Synchronizer
	// --------------------
	always_ff @(posedge clk14m or negedge ff_reset_n) begin
		if (!ff_reset_n) begin
			ff_sync0 <= 2'b00;
			ff_sync1 <= 2'b00;
			ff_prev  <= 2'b00;
		end else begin
			ff_sync0 <= button;
			ff_sync1 <= ff_sync0;
			ff_prev  <= ff_sync1;
		end
	end

	// Press means a low-to-high step of the clean level
	assign w_rise = ff_sync1 & ~ff_prev;

	// No request at all into a full queue
	assign w_req = (w_rise != 2'b00) && !full;

	// --------------------
	// Request strobe
	// --------------------
	always_ff @(posedge clk14m or negedge ff_reset_n) begin
		if (!ff_reset_n) begin
			wr <= 1'b0;
		end else begin
			wr <= w_req;		// High for exactly one cycle per press
		end
	end

	// Colour payload, only meaningful while wr is high
	always_ff @(posedge clk14m) begin
		if (w_req) begin
			if (w_rise[0]) begin
				wdata <= led_pkg::BUTTON0_GRB;		// Button 0 wins a tie
			end else begin
				wdata <= led_pkg::BUTTON1_GRB;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/led_pkg.sv */
`default_nettype none

package led_pkg;

	// --------------------
	// Colour words
	// --------------------
	typedef logic [7:0]  color_t;		// One channel intensity
	typedef logic [23:0] grb_t;			// WS2812 wire order, MSB first

	// Pack one WS2812 word, green goes out first
	function automatic grb_t make_grb(
		input color_t red,
		input color_t green,
		input color_t blue
	);
		return {green, red, blue};
	endfunction

	// Button presets
	parameter grb_t BUTTON0_GRB = make_grb(8'd100, 8'd20, 8'd0);		// Warm red
	parameter grb_t BUTTON1_GRB = make_grb(8'd0, 8'd70, 8'd100);		// Cyan blue

	// --------------------
	// Serializer
	// --------------------
	typedef enum logic [1:0] {
		ST_IDLE,		// Waiting for a queued colour
		ST_HIGH,		// High part of a bit
		ST_LOW,			// Low part of a bit
		ST_LATCH		// Reset low period after the frame
	} ser_state_t;

	// Bit timing at clk14m, about 70 ns per cycle
	parameter int T0H_CYCLES = 5;		// About 350 ns
	parameter int T1H_CYCLES = 10;		// About 700 ns
	parameter int BIT_CYCLES = 18;		// About 1.26 us per bit

endpackage

`default_nettype wire
